// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = ring_snapshot_tb
FILELIST  = list.f
BUILD     = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "=== PASS ===" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== list.f ====
verilog/ring_pkg.sv
verilog/sample_ring.sv
verilog/snapshot_bank.sv
verilog/snapshot_sequencer.sv
verilog/ring_snapshot_top.sv
testbench/tb_clock.sv
testbench/ring_snapshot_checker.sv
testbench/ring_snapshot_tb.sv

// ==== testbench/ring_snapshot_checker.sv ====
`timescale 1ns/1ps

module ring_snapshot_checker (
    input logic              clk,
    input logic              reset,
    input logic              save_state,
    input logic              restore_state,
    input ring_pkg::sample_t sample_out,
    input logic              busy,
    input logic              done
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Sequencer protocol
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    a_idle_after_reset: assert property (@(posedge clk) $fell(reset) |-> !busy)
        else $error("busy is high in the first cycle after reset");

    a_done_after_busy: assert property (@(posedge clk) disable iff (reset)
        done |-> $fell(busy))
        else $error("done rose without a fall of busy");

    a_done_single: assert property (@(posedge clk) disable iff (reset)
        done |=> !done)
        else $error("done lasted more than one cycle");

    // The ring stays frozen for the whole copy.
    a_frozen_when_busy: assert property (@(posedge clk) disable iff (reset)
        busy |=> $stable(sample_out))
        else $error("ring advanced during a copy");

    a_strobe_starts_copy: assert property (@(posedge clk) disable iff (reset)
        (!busy && (save_state || restore_state)) |=> busy)
        else $error("accepted strobe did not raise busy");

endmodule

bind ring_snapshot_top ring_snapshot_checker u_ring_snapshot_checker (
    .clk           (clk),
    .reset         (reset),
    .save_state    (save_state),
    .restore_state (restore_state),
    .sample_out    (sample_out),
    .busy          (busy),
    .done          (done)
);

// ==== testbench/ring_snapshot_tb.sv ====
`timescale 1ns/1ps

module ring_snapshot_tb;

    logic              clk;
    logic              reset;
    logic              save_state;
    logic              restore_state;
    ring_pkg::page_t   save_page;
    ring_pkg::page_t   restore_page;
    ring_pkg::sample_t sample_in;
    ring_pkg::sample_t sample_out;
    logic              busy;
    logic              done;

    integer seed;
    int     error_count       = 0;
    int     check_count       = 0;
    int     tests_run         = 0;
    int     tests_failed      = 0;
    int     test_start_errors = 0;

    // Reference copy of the ring, the pages and the sequencer.
    ring_pkg::sample_t    ref_ring [ring_pkg::ring_depth];
    ring_pkg::sample_t    ref_pages [ring_pkg::page_count][ring_pkg::ring_depth];
    ring_pkg::addr_t      ref_index;
    ring_pkg::addr_t      ref_addr;
    ring_pkg::page_t      ref_page;
    ring_pkg::sample_t    ref_out;
    ring_pkg::seq_state_t ref_state;
    logic                 ref_done;

    tb_clock u_tb_clock (
        .clk (clk)
    );

    ring_snapshot_top u_ring_snapshot_top (
        .clk           (clk),
        .reset         (reset),
        .save_state    (save_state),
        .restore_state (restore_state),
        .save_page     (save_page),
        .restore_page  (restore_page),
        .sample_in     (sample_in),
        .sample_out    (sample_out),
        .busy          (busy),
        .done          (done)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic void model_reset();
        for (int i = 0; i < ring_pkg::ring_depth; i++) begin
            ref_ring[i] = ring_pkg::sample_t'(ring_pkg::reset_base + i);
            for (int p = 0; p < ring_pkg::page_count; p++) begin
                ref_pages[p][i] = '0;
            end
        end
        ref_index = '0;
        ref_addr  = '0;
        ref_page  = '0;
        ref_out   = '0;
        ref_state = ring_pkg::seq_idle;
        ref_done  = 1'b0;
    endfunction

    // One clock edge of the expected behavior.
    function automatic void model_step(input logic save, input logic restore,
                                       input ring_pkg::page_t spage,
                                       input ring_pkg::page_t rpage,
                                       input ring_pkg::sample_t sample);
        ref_done = 1'b0;
        if (ref_state == ring_pkg::seq_idle) begin
            ref_out             = ref_ring[ref_index];
            ref_ring[ref_index] = sample;
            ref_index           = ref_index + ring_pkg::addr_t'(1);
            ref_addr            = '0;
            if (save) begin
                ref_state = ring_pkg::seq_saving;        // Save wins a tie.
                ref_page  = spage;
            end else if (restore) begin
                ref_state = ring_pkg::seq_restoring;
                ref_page  = rpage;
            end
        end else begin
            if (ref_state == ring_pkg::seq_saving) begin
                ref_pages[ref_page][ref_addr] = ref_ring[ref_addr];
            end else begin
                ref_ring[ref_addr] = ref_pages[ref_page][ref_addr];
            end
            if (ref_addr == ring_pkg::addr_t'(ring_pkg::ring_depth - 1)) begin
                ref_state = ring_pkg::seq_idle;
                ref_done  = 1'b1;
            end
            ref_addr = ref_addr + ring_pkg::addr_t'(1);
        end
    endfunction

    always @(posedge clk) begin
        if (reset) begin
            model_reset();
        end else begin
            model_step(save_state, restore_state, save_page, restore_page, sample_in);
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Compare
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic check_sample(input ring_pkg::sample_t got, input ring_pkg::sample_t exp,
                                input string what);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("MISMATCH at %0t: %s got %02h expected %02h", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("MISMATCH at %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    always @(negedge clk) begin
        if (!reset) begin
            check_sample(sample_out, ref_out, "sample_out");
            check_flag(busy, ref_state != ring_pkg::seq_idle, "busy");
            check_flag(done, ref_done, "done");
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus tasks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Free running stream, optionally checked against base plus step times i.
    task automatic stream_cycles(input int n, input logic check_fill,
                                 input int fill_base, input int fill_step);
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            sample_in     <= ring_pkg::sample_t'($random(seed));
            save_state    <= 1'b0;
            restore_state <= 1'b0;
            @(negedge clk);
            if (check_fill) begin
                check_sample(sample_out, ring_pkg::sample_t'(fill_base + fill_step * i),
                             "fill value");
            end
        end
    endtask

    task automatic issue_strobe(input logic save, input logic restore,
                                input ring_pkg::page_t spage, input ring_pkg::page_t rpage);
        @(posedge clk);
        save_state    <= save;
        restore_state <= restore;
        save_page     <= spage;
        restore_page  <= rpage;
        sample_in     <= ring_pkg::sample_t'($random(seed));
    endtask

    // Waits for done; inject throws both strobes at the DUT mid copy.
    task automatic wait_copy(input logic inject);
        int busy_cycles;
        int waited;
        busy_cycles = 0;
        waited      = 0;
        @(posedge clk);                                  // Edge that takes the strobe.
        save_state    <= 1'b0;
        restore_state <= 1'b0;
        sample_in     <= ring_pkg::sample_t'($random(seed));
        @(negedge clk);
        while (done !== 1'b1 && waited < 2 * ring_pkg::ring_depth) begin
            if (busy === 1'b1) begin
                busy_cycles++;
            end
            @(posedge clk);
            save_state    <= inject && (waited == 40);
            restore_state <= inject && (waited == 40);
            save_page     <= 4'd1;
            restore_page  <= 4'd2;
            sample_in     <= ring_pkg::sample_t'($random(seed));
            @(negedge clk);
            waited++;
        end
        if (done !== 1'b1) begin
            error_count++;
            $display("Copy did not finish: no done pulse within %0d cycles.", waited);
        end
        check_flag(logic'(busy_cycles == ring_pkg::ring_depth), 1'b1, "busy length");
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (error_count == test_start_errors) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed with %0d errors", tests_run, name,
                     error_count - test_start_errors);
        end
        test_start_errors = error_count;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Test sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin : stimulus
        seed          = 32'hc23f_ea4c;
        reset         = 1'b1;
        save_state    = 1'b0;
        restore_state = 1'b0;
        save_page     = '0;
        restore_page  = '0;
        sample_in     = '0;
        model_reset();
        repeat (10) @(posedge clk);
        reset <= 1'b0;

        stream_cycles(ring_pkg::ring_depth, 1'b1, ring_pkg::reset_base, 1);
        finish_test("reset_contents");

        stream_cycles(300, 1'b0, 0, 0);
        finish_test("delay_line");

        issue_strobe(1'b1, 1'b0, 4'd5, 4'd0);
        wait_copy(1'b0);
        stream_cycles(60, 1'b0, 0, 0);
        issue_strobe(1'b0, 1'b1, 4'd0, 4'd5);
        wait_copy(1'b0);
        stream_cycles(ring_pkg::ring_depth, 1'b0, 0, 0);
        finish_test("save_restore");

        issue_strobe(1'b0, 1'b1, 4'd0, 4'd9);
        wait_copy(1'b0);
        stream_cycles(ring_pkg::ring_depth, 1'b1, 0, 0);  // Blank page reads zero.
        finish_test("unwritten_page");

        issue_strobe(1'b1, 1'b0, 4'd11, 4'd0);
        wait_copy(1'b1);
        stream_cycles(20, 1'b0, 0, 0);
        issue_strobe(1'b0, 1'b1, 4'd0, 4'd11);
        wait_copy(1'b1);
        stream_cycles(ring_pkg::ring_depth, 1'b0, 0, 0);
        finish_test("busy_rules");

        issue_strobe(1'b1, 1'b1, 4'd2, 4'd9);
        wait_copy(1'b0);
        stream_cycles(40, 1'b0, 0, 0);
        issue_strobe(1'b1, 1'b0, 4'd7, 4'd0);
        wait_copy(1'b0);
        stream_cycles(30, 1'b0, 0, 0);
        issue_strobe(1'b0, 1'b1, 4'd0, 4'd2);
        wait_copy(1'b0);
        stream_cycles(ring_pkg::ring_depth, 1'b0, 0, 0);
        issue_strobe(1'b0, 1'b1, 4'd0, 4'd7);
        wait_copy(1'b0);
        stream_cycles(ring_pkg::ring_depth, 1'b0, 0, 0);
        finish_test("priority_and_pages");

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, check_count, error_count);
        if (error_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // Cycle budget follows the test sequence above.
    initial begin : watchdog
        int copy_cycles;
        int test_cycles;
        int limit_cycles;
        copy_cycles  = ring_pkg::ring_depth + 4;
        test_cycles  = 128 + 300 + (2 * copy_cycles + 188) + (copy_cycles + 128)
                       + (2 * copy_cycles + 148) + (4 * copy_cycles + 326);
        limit_cycles = 10 + test_cycles + 500;
        #(limit_cycles * 40);
        $display("Timeout: the run did not finish within %0d clock cycles.", limit_cycles);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

// ==== testbench/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;                              // 40 ns period.
        end
    end

endmodule

// ==== verilog/ring_pkg.sv ====
package ring_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Sizes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int ring_depth   = 128;                   // Live ring entries.
    localparam int page_count   = 16;                    // Snapshot pages.
    localparam int reset_base   = 32;                    // Entry i resets to base plus i.

    localparam int sample_width = 8;
    localparam int addr_width   = $clog2(ring_depth);
    localparam int page_width   = $clog2(page_count);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Types
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // One stream sample.
    typedef logic [sample_width-1:0] sample_t;

    // Index into the ring or into one page.
    typedef logic [addr_width-1:0] addr_t;

    // Snapshot page number.
    typedef logic [page_width-1:0] page_t;

    // Final copy address, the sequencer leaves its copy state after it.
    localparam addr_t last_addr = addr_t'(ring_depth - 1);

    // Copy sequencer states.
    typedef enum logic [1:0] {
        seq_idle,                                        // Ring rotates.
        seq_saving,                                      // Ring to page.
        seq_restoring                                    // Page to ring.
    } seq_state_t;

endpackage

// ==== verilog/ring_snapshot_top.sv ====
`timescale 1ns/1ps

module ring_snapshot_top (
    input  logic              clk,
    input  logic              reset,
    input  logic              save_state,
    input  logic              restore_state,
    input  ring_pkg::page_t   save_page,
    input  ring_pkg::page_t   restore_page,
    input  ring_pkg::sample_t sample_in,
    output ring_pkg::sample_t sample_out,
    output logic              busy,
    output logic              done
);

    logic              advance;
    logic              ring_we;
    logic              bank_we;
    ring_pkg::addr_t   copy_addr;
    ring_pkg::page_t   copy_page;
    ring_pkg::sample_t ring_rdata;                       // Ring entry toward the bank.
    ring_pkg::sample_t bank_rdata;                       // Page entry toward the ring.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Datapath
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    sample_ring u_sample_ring (
        .clk        (clk),
        .reset      (reset),
        .advance    (advance),
        .sample_in  (sample_in),
        .sample_out (sample_out),
        .copy_addr  (copy_addr),
        .copy_rdata (ring_rdata),
        .copy_we    (ring_we),
        .copy_wdata (bank_rdata)
    );

    snapshot_bank u_snapshot_bank (
        .clk      (clk),
        .reset    (reset),
        .write_en (bank_we),
        .page     (copy_page),
        .addr     (copy_addr),
        .wdata    (ring_rdata),
        .rdata    (bank_rdata)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Control
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    snapshot_sequencer u_snapshot_sequencer (
        .clk           (clk),
        .reset         (reset),
        .save_state    (save_state),
        .restore_state (restore_state),
        .save_page     (save_page),
        .restore_page  (restore_page),
        .advance       (advance),
        .copy_page     (copy_page),
        .copy_addr     (copy_addr),
        .ring_we       (ring_we),
        .bank_we       (bank_we),
        .busy          (busy),
        .done          (done)
    );

endmodule

// ==== verilog/sample_ring.sv ====
`timescale 1ns/1ps

module sample_ring (
    input  logic              clk,
    input  logic              reset,
    input  logic              advance,
    input  ring_pkg::sample_t sample_in,
    output ring_pkg::sample_t sample_out,
    input  ring_pkg::addr_t   copy_addr,
    output ring_pkg::sample_t copy_rdata,
    input  logic              copy_we,
    input  ring_pkg::sample_t copy_wdata
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Storage
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    ring_pkg::sample_t ring_mem [ring_pkg::ring_depth];
    ring_pkg::addr_t   index;                            // Shared read and write slot.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Array update
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // The sequencer never raises copy_we together with advance, so the two
    // write paths below do not collide.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < ring_pkg::ring_depth; i++) begin
                ring_mem[i] <= ring_pkg::sample_t'(ring_pkg::reset_base + i);
            end
        end else if (advance) begin
            ring_mem[index] <= sample_in;                // Overwrite after the read.
        end else if (copy_we) begin
            ring_mem[copy_addr] <= copy_wdata;           // Restore one entry.
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Rotation
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            index <= '0;
        end else if (advance) begin
            index <= index + ring_pkg::addr_t'(1);       // Wraps at ring_depth.
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sample_out <= '0;
        end else if (advance) begin
            sample_out <= ring_mem[index];               // Oldest sample leaves.
        end
    end

    // Copy port read, used while saving.
    assign copy_rdata = ring_mem[copy_addr];

endmodule

// ==== verilog/snapshot_bank.sv ====
`timescale 1ns/1ps

module snapshot_bank (
    input  logic              clk,
    input  logic              reset,
    input  logic              write_en,
    input  ring_pkg::page_t   page,
    input  ring_pkg::addr_t   addr,
    input  ring_pkg::sample_t wdata,
    output ring_pkg::sample_t rdata
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Page storage
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    ring_pkg::sample_t bank_mem [ring_pkg::page_count][ring_pkg::ring_depth];

    // Pages that were never saved read back as zero.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int p = 0; p < ring_pkg::page_count; p++) begin
                for (int e = 0; e < ring_pkg::ring_depth; e++) begin
                    bank_mem[p][e] <= '0;
                end
            end
        end else if (write_en) begin
            bank_mem[page][addr] <= wdata;               // One entry per cycle.
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Read port
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Combinational, so a restore moves one entry on every cycle.
    assign rdata = bank_mem[page][addr];

endmodule

// ==== verilog/snapshot_sequencer.sv ====
`timescale 1ns/1ps

module snapshot_sequencer (
    input  logic            clk,
    input  logic            reset,
    input  logic            save_state,
    input  logic            restore_state,
    input  ring_pkg::page_t save_page,
    input  ring_pkg::page_t restore_page,
    output logic            advance,
    output ring_pkg::page_t copy_page,
    output ring_pkg::addr_t copy_addr,
    output logic            ring_we,
    output logic            bank_we,
    output logic            busy,
    output logic            done
);

    ring_pkg::seq_state_t state;
    ring_pkg::seq_state_t next_state;
    logic                 last_step;

    assign last_step = (copy_addr == ring_pkg::last_addr);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // State machine
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        next_state = state;
        case (state)
            ring_pkg::seq_idle: begin
                if (save_state) begin
                    next_state = ring_pkg::seq_saving;       // Save has priority.
                end else if (restore_state) begin
                    next_state = ring_pkg::seq_restoring;
                end
            end
            ring_pkg::seq_saving,
            ring_pkg::seq_restoring: begin
                if (last_step) begin
                    next_state = ring_pkg::seq_idle;
                end
            end
            default: begin
                next_state = ring_pkg::seq_idle;
            end
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= ring_pkg::seq_idle;
        end else begin
            state <= next_state;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Page latch and address walk
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Strobes during a copy fall through here untouched.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            copy_page <= '0;
            copy_addr <= '0;
        end else if (state == ring_pkg::seq_idle) begin
            copy_addr <= '0;
            if (save_state) begin
                copy_page <= save_page;
            end else if (restore_state) begin
                copy_page <= restore_page;
            end
        end else begin
            copy_addr <= copy_addr + ring_pkg::addr_t'(1); // Back to 0 after 127.
        end
    end

    // One pulse in the first idle cycle after a copy.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            done <= 1'b0;
        end else begin
            done <= (state != ring_pkg::seq_idle) && last_step;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Decoded controls
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign advance = (state == ring_pkg::seq_idle);           // Ring frozen otherwise.
    assign busy    = (state != ring_pkg::seq_idle);
    assign bank_we = (state == ring_pkg::seq_saving);
    assign ring_we = (state == ring_pkg::seq_restoring);

endmodule
